//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

    localparam int POS_W = 12;    // Raster counter width.

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    localparam pixel_t BLACK = '0;

    // Raster position with its visible-area flag.
    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
        logic             active;
    } scan_pos_t;

    typedef struct packed {
        pixel_t color;
        logic   hsync;
        logic   vsync;
        logic   de;
    } video_out_t;

    typedef struct packed {
        logic enable;
        logic line_double;    // Each stored row shown on two lines.
        logic add_line;       // One extra blank line per frame.
    } mode_t;

endpackage

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int WB_ADR_W    = 4;
    localparam int WB_DAT_W    = 32;
    localparam int FRAME_CNT_W = 16;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // Register map.
    localparam logic [WB_ADR_W-1:0] ADDR_CTRL   = 4'd0;
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS = 4'd1;

    // CTRL field positions.
    localparam int CTRL_ENABLE_BIT      = 0;
    localparam int CTRL_LINE_DOUBLE_BIT = 1;
    localparam int CTRL_ADD_LINE_BIT    = 2;

endpackage

`default_nettype wire

//--- logic/video_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module video_ctrl (
    input  logic              clock,
    input  logic              reset,
    input  bus_pkg::wb_req_t  wb_req,
    output bus_pkg::wb_rsp_t  wb_rsp,
    input  logic              frame_end,
    output video_pkg::mode_t  mode,
    output logic              restart
);

    import bus_pkg::*;
    import video_pkg::*;

    logic                   req;
    logic                   wr_ctrl;
    mode_t                  wr_mode;
    logic [FRAME_CNT_W-1:0] frame_count;
    logic [WB_DAT_W-1:0]    rd_word;

    // New request only when the previous cycle was not an ack.
    assign req     = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wr_ctrl = req && wb_req.we && (wb_req.adr == ADDR_CTRL);

    assign wr_mode.enable      = wb_req.dat[CTRL_ENABLE_BIT];
    assign wr_mode.line_double = wb_req.dat[CTRL_LINE_DOUBLE_BIT];
    assign wr_mode.add_line    = wb_req.dat[CTRL_ADD_LINE_BIT];

    always_comb begin
        rd_word = '0;
        case (wb_req.adr)
            ADDR_CTRL: begin
                rd_word[CTRL_ENABLE_BIT]      = mode.enable;
                rd_word[CTRL_LINE_DOUBLE_BIT] = mode.line_double;
                rd_word[CTRL_ADD_LINE_BIT]    = mode.add_line;
            end
            ADDR_STATUS: begin
                rd_word = WB_DAT_W'(frame_count);
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        wb_rsp.dat <= rd_word;    // Valid with ack.
        if (!reset) begin
            wb_rsp.ack <= 1'b0;
            mode       <= '0;
            restart    <= 1'b0;
        end else begin
            wb_rsp.ack <= req;
            restart    <= wr_ctrl && (wr_mode != mode);
            if (wr_ctrl) begin
                mode <= wr_mode;
            end
        end
    end

    // Completed frames since the last restart.
    always_ff @(posedge clock) begin
        if (!reset) begin
            frame_count <= '0;
        end else if (restart) begin
            frame_count <= '0;
        end else if (frame_end) begin
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
    parameter int BUF_DEPTH = 60
) (
    input  logic                         clock,
    input  logic                         wr_en,
    input  logic [$clog2(BUF_DEPTH)-1:0] wr_addr,
    input  video_pkg::pixel_t            wr_data,
    input  logic [$clog2(BUF_DEPTH)-1:0] rd_addr,
    output video_pkg::pixel_t            rd_data
);

    import video_pkg::*;

    pixel_t mem [BUF_DEPTH];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle of latency.
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- logic/pixel_capture.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_capture #(
    parameter int BUF_DEPTH = 60
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         pix_valid,
    input  logic                         pix_sof,
    input  video_pkg::pixel_t            pix_data,
    output logic                         wr_en,
    output logic [$clog2(BUF_DEPTH)-1:0] wr_addr,
    output video_pkg::pixel_t            wr_data
);

    localparam int AW = $clog2(BUF_DEPTH);
    localparam logic [AW-1:0] LAST = AW'(BUF_DEPTH - 1);

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] cur_addr;

    // Start of frame forces address zero.
    assign cur_addr = pix_sof ? '0 : wr_ptr;

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            wr_en  <= 1'b0;
        end else begin
            wr_en <= pix_valid;
            if (pix_valid) begin
                wr_ptr <= (cur_addr == LAST) ? '0 : cur_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        wr_addr <= cur_addr;
        wr_data <= pix_data;
    end

endmodule

`default_nettype wire

//--- scanout/scan_timing.sv
`timescale 1ns/1ps
`default_nettype none

module scan_timing #(
    parameter int   H_TOTAL     = 16,
    parameter int   H_VISIBLE   = 10,
    parameter int   HSYNC_START = 12,
    parameter int   HSYNC_WIDTH = 2,
    parameter int   V_TOTAL     = 8,
    parameter int   V_VISIBLE   = 6,
    parameter int   VSYNC_START = 7,
    parameter int   VSYNC_WIDTH = 1,
    parameter logic HSYNC_POL   = 1'b0,
    parameter logic VSYNC_POL   = 1'b0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  video_pkg::mode_t     mode,
    input  logic                 restart,
    output video_pkg::scan_pos_t pos,
    output logic                 hsync_raw,
    output logic                 vsync_raw,
    output logic                 frame_end
);

    import video_pkg::*;

    localparam logic [POS_W-1:0] H_LAST   = POS_W'(H_TOTAL - 1);
    localparam logic [POS_W-1:0] H_VIS    = POS_W'(H_VISIBLE);
    localparam logic [POS_W-1:0] HS_BEGIN = POS_W'(HSYNC_START);
    localparam logic [POS_W-1:0] HS_END   = POS_W'(HSYNC_START + HSYNC_WIDTH);
    localparam logic [POS_W-1:0] V_LAST   = POS_W'(V_TOTAL - 1);
    localparam logic [POS_W-1:0] V_VIS    = POS_W'(V_VISIBLE);
    localparam logic [POS_W-1:0] VS_BEGIN = POS_W'(VSYNC_START);
    localparam logic [POS_W-1:0] VS_END   = POS_W'(VSYNC_START + VSYNC_WIDTH);

    logic [POS_W-1:0] x;
    logic [POS_W-1:0] y;
    logic [POS_W-1:0] y_last;
    logic             x_wrap;
    logic             y_wrap;
    logic             hs_on;
    logic             vs_on;

    assign y_last = mode.add_line ? V_LAST + 1'b1 : V_LAST;    // Interlace-style extra line.
    assign x_wrap = (x == H_LAST);
    assign y_wrap = (y == y_last);

    assign hs_on = (x >= HS_BEGIN) && (x < HS_END);
    assign vs_on = (y >= VS_BEGIN) && (y < VS_END);

    assign pos.x      = x;
    assign pos.y      = y;
    assign pos.active = mode.enable && (x < H_VIS) && (y < V_VIS);

    always_ff @(posedge clock) begin
        if (!reset) begin
            x         <= '0;
            y         <= '0;
            frame_end <= 1'b0;
        end else if (restart) begin
            x         <= '0;
            y         <= '0;
            frame_end <= 1'b0;
        end else begin
            frame_end <= mode.enable && x_wrap && y_wrap;
            if (mode.enable) begin
                x <= x_wrap ? '0 : x + 1'b1;
                if (x_wrap) begin
                    y <= y_wrap ? '0 : y + 1'b1;
                end
            end
        end
    end

    // One clock behind the counters, same as the RAM data.
    always_ff @(posedge clock) begin
        if (!reset) begin
            hsync_raw <= ~HSYNC_POL;
            vsync_raw <= ~VSYNC_POL;
        end else begin
            hsync_raw <= (mode.enable && hs_on) ? HSYNC_POL : ~HSYNC_POL;
            vsync_raw <= (mode.enable && vs_on) ? VSYNC_POL : ~VSYNC_POL;
        end
    end

endmodule

`default_nettype wire

//--- scanout/pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_out #(
    parameter int H_VISIBLE = 10,
    parameter int BUF_DEPTH = 60
) (
    input  logic                         clock,
    input  logic                         reset,
    input  video_pkg::mode_t             mode,
    input  video_pkg::scan_pos_t         pos,
    input  logic                         hsync_raw,
    input  logic                         vsync_raw,
    output logic [$clog2(BUF_DEPTH)-1:0] rd_addr,
    input  video_pkg::pixel_t            rd_data,
    output video_pkg::video_out_t        video
);

    import video_pkg::*;

    localparam int ADDR_W = 2 * POS_W;
    localparam int AW     = $clog2(BUF_DEPTH);
    localparam logic [ADDR_W-1:0] H_VIS = ADDR_W'(H_VISIBLE);

    logic [POS_W-1:0]  row;
    logic [ADDR_W-1:0] addr_full;
    logic              active_d;

    // Line doubling shows stored row y/2.
    assign row       = mode.line_double ? {1'b0, pos.y[POS_W-1:1]} : pos.y;
    assign addr_full = ADDR_W'(row) * H_VIS + ADDR_W'(pos.x);
    assign rd_addr   = pos.active ? addr_full[AW-1:0] : '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            active_d <= 1'b0;
        end else begin
            active_d <= pos.active;    // Matches RAM latency.
        end
    end

    always_ff @(posedge clock) begin
        video.hsync <= hsync_raw;
        video.vsync <= vsync_raw;
        if (!reset) begin
            video.de    <= 1'b0;
            video.color <= BLACK;
        end else begin
            video.de    <= active_d;
            video.color <= active_d ? rd_data : BLACK;    // Blank outside draw area.
        end
    end

endmodule

`default_nettype wire

//--- logic/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top #(
    parameter int   H_TOTAL     = 16,
    parameter int   H_VISIBLE   = 10,
    parameter int   HSYNC_START = 12,
    parameter int   HSYNC_WIDTH = 2,
    parameter int   V_TOTAL     = 8,
    parameter int   V_VISIBLE   = 6,
    parameter int   VSYNC_START = 7,
    parameter int   VSYNC_WIDTH = 1,
    parameter logic HSYNC_POL   = 1'b0,
    parameter logic VSYNC_POL   = 1'b0,
    parameter int   BUF_DEPTH   = H_VISIBLE * V_VISIBLE
) (
    input  logic                  clock,
    input  logic                  reset,
    input  bus_pkg::wb_req_t      wb_req,
    output bus_pkg::wb_rsp_t      wb_rsp,
    input  logic                  pix_valid,
    input  logic                  pix_sof,
    input  video_pkg::pixel_t     pix_data,
    output video_pkg::video_out_t video
);

    import video_pkg::*;

    localparam int AW = $clog2(BUF_DEPTH);

    mode_t          mode;
    logic           restart;
    logic           frame_end;
    logic           wr_en;
    logic [AW-1:0]  wr_addr;
    pixel_t         wr_data;
    logic [AW-1:0]  rd_addr;
    pixel_t         rd_data;
    scan_pos_t      pos;
    logic           hsync_raw;
    logic           vsync_raw;

    video_ctrl u_ctrl (
        .clock     (clock),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .frame_end (frame_end),
        .mode      (mode),
        .restart   (restart)
    );

    pixel_capture #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_capture (
        .clock     (clock),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_sof   (pix_sof),
        .pix_data  (pix_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    line_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buffer (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    scan_timing #(
        .H_TOTAL     (H_TOTAL),
        .H_VISIBLE   (H_VISIBLE),
        .HSYNC_START (HSYNC_START),
        .HSYNC_WIDTH (HSYNC_WIDTH),
        .V_TOTAL     (V_TOTAL),
        .V_VISIBLE   (V_VISIBLE),
        .VSYNC_START (VSYNC_START),
        .VSYNC_WIDTH (VSYNC_WIDTH),
        .HSYNC_POL   (HSYNC_POL),
        .VSYNC_POL   (VSYNC_POL)
    ) u_timing (
        .clock     (clock),
        .reset     (reset),
        .mode      (mode),
        .restart   (restart),
        .pos       (pos),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .frame_end (frame_end)
    );

    pixel_out #(
        .H_VISIBLE (H_VISIBLE),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_out (
        .clock     (clock),
        .reset     (reset),
        .mode      (mode),
        .pos       (pos),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .video     (video)
    );

endmodule

`default_nettype wire

//--- dv/video_checker.sv
`timescale 1ns/1ps
`default_nettype none

module video_checker #(
    parameter logic VSYNC_POL = 1'b0
) (
    input logic                  clock,
    input logic                  reset,
    input bus_pkg::wb_rsp_t      wb_rsp,
    input video_pkg::video_out_t video
);

    import video_pkg::*;

    blank_color: assert property (@(posedge clock) disable iff (!reset)
        !video.de |-> video.color == BLACK)
        else $error("Color is nonzero while de is low");

    ack_single: assert property (@(posedge clock) disable iff (!reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("Wishbone ack stayed high for two cycles");

    // Visible lines never overlap the vsync pulse.
    de_outside_vsync: assert property (@(posedge clock) disable iff (!reset)
        $rose(video.de) |-> video.vsync != VSYNC_POL)
        else $error("de rose while vsync was active");

endmodule

bind video_top video_checker #(
    .VSYNC_POL (VSYNC_POL)
) u_checker (
    .clock  (clock),
    .reset  (reset),
    .wb_rsp (wb_rsp),
    .video  (video)
);

`default_nettype wire

//--- dv/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_tb;

    import video_pkg::*;
    import bus_pkg::*;

    localparam int   H_TOTAL      = 16;
    localparam int   H_VISIBLE    = 10;
    localparam int   HSYNC_START  = 12;
    localparam int   HSYNC_WIDTH  = 2;
    localparam int   V_TOTAL      = 8;
    localparam int   V_VISIBLE    = 6;
    localparam int   VSYNC_START  = 7;
    localparam int   VSYNC_WIDTH  = 1;
    localparam logic HSYNC_POL    = 1'b0;
    localparam logic VSYNC_POL    = 1'b0;
    localparam int   BUF_DEPTH    = H_VISIBLE * V_VISIBLE;
    localparam int   FRAME_CYCLES = H_TOTAL * (V_TOTAL + 1);
    // About 20 frames of tests plus the buffer loads, with margin.
    localparam int   CYCLE_LIMIT  = 30 * FRAME_CYCLES + 2 * BUF_DEPTH + 200;

    logic       clock;
    logic       reset;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       pix_valid;
    logic       pix_sof;
    pixel_t     pix_data;
    video_out_t video;

    pixel_t      ref_buf [BUF_DEPTH];    // Mirror of the frame buffer.
    pixel_t      frame [BUF_DEPTH];      // Last captured visible area.
    int          wr_ptr;
    logic [15:0] lfsr;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    video_top #(
        .H_TOTAL     (H_TOTAL),
        .H_VISIBLE   (H_VISIBLE),
        .HSYNC_START (HSYNC_START),
        .HSYNC_WIDTH (HSYNC_WIDTH),
        .V_TOTAL     (V_TOTAL),
        .V_VISIBLE   (V_VISIBLE),
        .VSYNC_START (VSYNC_START),
        .VSYNC_WIDTH (VSYNC_WIDTH),
        .HSYNC_POL   (HSYNC_POL),
        .VSYNC_POL   (VSYNC_POL),
        .BUF_DEPTH   (BUF_DEPTH)
    ) DUT (
        .clock     (clock),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .pix_valid (pix_valid),
        .pix_sof   (pix_sof),
        .pix_data  (pix_data),
        .video     (video)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %06h, actual %06h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_video(input string name, input video_out_t expected,
                               input video_out_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %07h, actual %07h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("%s: %s, %0d errors", name, (errors == start_errors) ? "ok" : "failed",
                 errors - start_errors);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic next_pixel(output pixel_t p);
        logic [23:0] bits;
        for (int i = 0; i < 24; i++) begin
            lfsr    = lfsr_step(lfsr);
            bits[i] = lfsr[0];
        end
        p = bits;
    endtask

    function automatic logic [31:0] ctrl_word(input logic en, input logic dbl, input logic add);
        logic [31:0] w;
        w                       = '0;
        w[CTRL_ENABLE_BIT]      = en;
        w[CTRL_LINE_DOUBLE_BIT] = dbl;
        w[CTRL_ADD_LINE_BIT]    = add;
        return w;
    endfunction

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(negedge clock);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clock);
        while (!wb_rsp.ack) @(negedge clock);
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic reg_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic reg_read(input logic [3:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic set_mode(input logic en, input logic dbl, input logic add);
        reg_write(ADDR_CTRL, ctrl_word(en, dbl, add));
        repeat (4) @(negedge clock);    // Flush the old raster out of the pipeline.
    endtask

    task automatic send_pixel(input logic sof);
        pixel_t p;
        next_pixel(p);
        @(negedge clock);
        pix_valid = 1'b1;
        pix_sof   = sof;
        pix_data  = p;
        if (sof) begin
            wr_ptr = 0;
        end
        ref_buf[wr_ptr] = p;
        wr_ptr          = (wr_ptr == BUF_DEPTH - 1) ? 0 : wr_ptr + 1;
    endtask

    task automatic stop_pixels();
        @(negedge clock);
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    task automatic wait_vsync_end();
        @(negedge clock);
        while (video.vsync != VSYNC_POL) @(negedge clock);
        while (video.vsync == VSYNC_POL) @(negedge clock);
    endtask

    // Collects the de-high pixels of the next whole frame.
    task automatic capture_frame(input string name);
        int n;
        int run;
        int lines;
        wait_vsync_end();
        n     = 0;
        run   = 0;
        lines = 0;
        while (lines < V_VISIBLE) begin
            if (video.de) begin
                if (n < BUF_DEPTH) begin
                    frame[n] = video.color;
                end
                n++;
                run++;
            end else if (run != 0) begin
                check_count($sformatf("%s line %0d length", name, lines), H_VISIBLE, run);
                lines++;
                run = 0;
            end
            @(negedge clock);
        end
        check_count({name, " visible pixels"}, BUF_DEPTH, n);
    endtask

    task automatic compare_frame(input string name, input logic doubled);
        int row;
        for (int l = 0; l < V_VISIBLE; l++) begin
            row = doubled ? l / 2 : l;
            for (int c = 0; c < H_VISIBLE; c++) begin
                check_pixel($sformatf("%s line %0d col %0d", name, l, c),
                            ref_buf[row * H_VISIBLE + c], frame[l * H_VISIBLE + c]);
            end
        end
    endtask

    task automatic test_reset_idle();
        int          start_errors;
        video_out_t  idle;
        logic [31:0] rdat;
        start_errors = errors;
        idle         = '0;
        idle.hsync   = ~HSYNC_POL;
        idle.vsync   = ~VSYNC_POL;
        repeat (2 * H_TOTAL) begin
            @(negedge clock);
            check_video("reset_idle output", idle, video);
        end
        reg_write(ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b1));
        reg_read(ADDR_CTRL, rdat);
        check_word("reset_idle ctrl readback", ctrl_word(1'b0, 1'b1, 1'b1), rdat);
        reg_read(ADDR_STATUS, rdat);
        check_word("reset_idle status", 32'd0, rdat);
        repeat (H_TOTAL) begin
            @(negedge clock);
            check_video("reset_idle disabled output", idle, video);
        end
        reg_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0));
        report_test("reset_idle", start_errors);
    endtask

    task automatic test_normal_frame();
        int          start_errors;
        logic [31:0] rdat;
        start_errors = errors;
        send_pixel(1'b1);
        repeat (BUF_DEPTH - 1) send_pixel(1'b0);
        stop_pixels();
        set_mode(1'b1, 1'b0, 1'b0);
        reg_read(ADDR_CTRL, rdat);
        check_word("normal_frame ctrl readback", ctrl_word(1'b1, 1'b0, 1'b0), rdat);
        capture_frame("normal_frame");
        compare_frame("normal_frame", 1'b0);
        report_test("normal_frame", start_errors);
    endtask

    task automatic test_line_double();
        int start_errors;
        start_errors = errors;
        set_mode(1'b1, 1'b1, 1'b0);
        capture_frame("line_double");
        compare_frame("line_double", 1'b1);
        report_test("line_double", start_errors);
    endtask

    // Hsync pulses from one vsync start to the next.
    task automatic measure_syncs(input string name, input int exp_lines);
        int   pulses;
        int   width;
        logic gap;
        wait_vsync_end();
        while (video.vsync != VSYNC_POL) @(negedge clock);
        pulses = 0;
        width  = 0;
        gap    = 1'b0;
        while (!(gap && video.vsync == VSYNC_POL)) begin
            if (video.vsync != VSYNC_POL) begin
                gap = 1'b1;
            end
            if (video.hsync == HSYNC_POL) begin
                width++;
            end else if (width != 0) begin
                check_count({name, " hsync width"}, HSYNC_WIDTH, width);
                pulses++;
                width = 0;
            end
            @(negedge clock);
        end
        check_count({name, " lines per frame"}, exp_lines, pulses);
    endtask

    task automatic test_sync_counts();
        int start_errors;
        start_errors = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        measure_syncs("sync_counts normal", V_TOTAL);
        set_mode(1'b1, 1'b0, 1'b1);
        measure_syncs("sync_counts add_line", V_TOTAL + 1);
        report_test("sync_counts", start_errors);
    endtask

    // Vsync ends exactly at the frame wrap here, so no extra line is used.
    task automatic test_frame_count();
        int          start_errors;
        logic [31:0] rdat;
        start_errors = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        repeat (3) wait_vsync_end();
        reg_read(ADDR_STATUS, rdat);
        check_word("frame_count after 3 frames", 32'd3, rdat);
        set_mode(1'b1, 1'b1, 1'b0);
        reg_read(ADDR_STATUS, rdat);
        check_word("frame_count after mode change", 32'd0, rdat);
        wait_vsync_end();
        reg_read(ADDR_STATUS, rdat);
        check_word("frame_count after 1 frame", 32'd1, rdat);
        report_test("frame_count", start_errors);
    endtask

    task automatic test_sof_restart();
        int start_errors;
        start_errors = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        repeat (13) send_pixel(1'b0);
        send_pixel(1'b1);    // Lands at address 0.
        repeat (2) send_pixel(1'b0);
        stop_pixels();
        capture_frame("sof_restart");
        check_pixel("sof_restart first pixel", ref_buf[0], frame[0]);
        compare_frame("sof_restart", 1'b0);
        report_test("sof_restart", start_errors);
    endtask

    initial begin
        reset     = 1'b0;
        wb_req    = '0;
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
        pix_data  = '0;
        lfsr      = 16'd28;
        wr_ptr    = 0;
        repeat (10) @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        test_reset_idle();
        test_normal_frame();
        test_line_double();
        test_sync_counts();
        test_frame_count();
        test_sof_restart();
        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/video_pkg.sv
common/bus_pkg.sv
logic/video_ctrl.sv
logic/line_buffer.sv
logic/pixel_capture.sv
scanout/scan_timing.sv
scanout/pixel_out.sv
logic/video_top.sv
dv/video_checker.sv
dv/video_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= video_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT  ?= TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
